// File: design/squash_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed display timing for 640x480 VGA at 25 MHz
// Court geometry: walls, paddle and ball sizes
// Reset and travel limits for the paddle and ball
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SQUASH_CONFIG_SVH
`define SQUASH_CONFIG_SVH

// Horizontal timing in pixel clocks
`define H_RES   640
`define H_FRONT 16
`define H_SYNC  96
`define H_BACK  48

// Vertical timing in lines
`define V_RES   480
`define V_FRONT 10
`define V_SYNC  2
`define V_BACK  33

`define H_FULL (`H_RES + `H_FRONT + `H_SYNC + `H_BACK)  // 800 clocks per line
`define V_FULL (`V_RES + `V_FRONT + `V_SYNC + `V_BACK)  // 525 lines per frame

`define PADDLE_SIZE  64  // Paddle height in pixels
`define BALL_SIZE    8   // Ball width and height in double pixels
`define WALL_WIDTH   32  // Thickness of the top, bottom and right walls

`define PADDLE_RESET 64   // Starting top line of the paddle
`define PADDLE_MIN   32   // Paddle stays below the top wall
`define PADDLE_MAX   384  // Paddle stays above the bottom wall
`define BALL_RESET   32   // Starting ball position on both axes, double pixels

`endif

// File: design/squashPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the squash game
// Scan coordinates, court coordinates, frame offset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package squashPkg;

  // One scan count, horizontal 0..799 or vertical 0..524
  typedef logic [9:0] scanCoord_t;

  // Ball column in double pixels
  // The ball moves on a 2x grid, so 9 bits cover the whole line
  typedef logic [8:0] courtX_t;

  // Ball row in double pixels
  // Half of the 480 visible lines fits in 8 bits
  typedef logic [7:0] courtY_t;

  // Top line of the paddle in real pixels
  // Never exceeds 384, so 9 bits are plenty
  typedef logic [8:0] paddlePos_t;

  // Background animation counter
  // Only bits 4:1 shift the pattern, the low bit slows it to half rate
  typedef logic [4:0] frameOffset_t;

endpackage

`default_nettype wire

// File: design/scanIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scan position bus from the timer to its users
// Carries h, v, end-of-line and end-of-frame flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface scanIf;

  squashPkg::scanCoord_t h;  // Pixel within the line
  squashPkg::scanCoord_t v;  // Line within the frame
  logic hMax;     // High for one clock on the last pixel of a line
  logic vMax;     // High for the whole last line of a frame
  logic visible;  // Scan is inside the 640x480 picture

  // The timer owns the scan
  modport timer (
    output h, v, hMax, vMax, visible
  );

  // Court and painter only look at it
  modport viewer (
    input h, v, hMax, vMax, visible
  );

endinterface

`default_nettype wire

// File: design/controlIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Player command bus, all levels active high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface controlIf;

  logic up;       // Move the paddle up
  logic down;     // Move the paddle down
  logic paused;   // Freeze the play at frame end
  logic newGame;  // Put paddle, ball and hit flag back to their start

  modport source (
    output up, down, paused, newGame
  );

  modport sink (
    input up, down, paused, newGame
  );

endinterface

`default_nettype wire

// File: design/scanTimer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VGA scan timer
// Pixel and line counters, end strobes, visible flag
// Active-low horizontal and vertical sync pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "squash_config.svh"

module scanTimer (
  input wire  clk,
  input wire  reset,
  scanIf.timer scan,
  output logic hsync,
  output logic vsync
);

  // Sync windows measured from the start of the line or frame
  localparam int hSyncStart = `H_RES + `H_FRONT;       // 656
  localparam int hSyncEnd   = hSyncStart + `H_SYNC;    // First pixel after the pulse, 752
  localparam int vSyncStart = `V_RES + `V_FRONT;       // 490
  localparam int vSyncEnd   = vSyncStart + `V_SYNC;    // 492

  assign scan.hMax = scan.h == squashPkg::scanCoord_t'(`H_FULL - 1);  // Single clock
  assign scan.vMax = scan.v == squashPkg::scanCoord_t'(`V_FULL - 1);  // Whole line

  // Picture area is the top left 640x480 of the scan
  assign scan.visible = (scan.h < `H_RES) && (scan.v < `V_RES);

  always_ff @(posedge clk) begin
    if (reset) begin
      scan.h <= '0;
      scan.v <= '0;
    end else begin
      // The pixel count runs every clock and wraps at the line end
      if (scan.hMax) begin
        scan.h <= '0;
      end else begin
        scan.h <= scan.h + 10'd1;
      end
      // Lines step on the last pixel, so v and h change together
      if (scan.hMax) begin
        if (scan.vMax) begin
          scan.v <= '0;
        end else begin
          scan.v <= scan.v + 10'd1;
        end
      end
    end
  end

  // Both pulses are low inside their window and high everywhere else
  assign hsync = ~((scan.h >= hSyncStart) && (scan.h < hSyncEnd));
  assign vsync = ~((scan.v >= vSyncStart) && (scan.v < vSyncEnd));

endmodule

`default_nettype wire

// File: design/playControls.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Button conditioning for the four player keys
// Two-flop synchronizers and active-low to high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module playControls (
  input wire  clk,
  input wire  reset,
  input wire  pauseN,
  input wire  newGameN,
  input wire  downKeyN,
  input wire  upKeyN,
  controlIf.source ctrl
);

  // Bit order in both stages: pause, new game, down, up
  logic [3:0] syncFirst;   // May go metastable, never read outside this block
  logic [3:0] syncSecond;  // Settled copy of the buttons, still active low

  always_ff @(posedge clk) begin
    if (reset) begin
      // Released buttons read as ones on the pins
      syncFirst  <= 4'b1111;
      syncSecond <= 4'b1111;
    end else begin
      syncFirst  <= {pauseN, newGameN, downKeyN, upKeyN};
      syncSecond <= syncFirst;  // A pin change shows up here after two clocks
    end
  end

  // The court only ever sees clean active-high commands
  assign ctrl.paused  = ~syncSecond[3];
  assign ctrl.newGame = ~syncSecond[2];
  assign ctrl.down    = ~syncSecond[1];
  assign ctrl.up      = ~syncSecond[0];

endmodule

`default_nettype wire

// File: design/courtState.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Court state of the squash game
// Paddle and ball positions with bounce directions
// Span flags that follow the scan over ball and paddle
// Collision, hit flag and speaker tone
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "squash_config.svh"

module courtState (
  input wire  clk,
  input wire  reset,
  scanIf.viewer scan,
  controlIf.sink ctrl,
  output logic inBall,
  output logic inPaddle,
  output logic speaker
);

  localparam int wallRLimit = `H_RES - `WALL_WIDTH;  // First pixel of the right wall
  localparam int wallBLimit = `V_RES - `WALL_WIDTH;  // First line of the bottom wall
  // Past this column the ball span would wrap around the line end
  localparam int ballXLimit = `H_RES / 2 - 2 * `BALL_SIZE;

  squashPkg::paddlePos_t paddle;  // Top line of the paddle
  squashPkg::courtX_t ballX;      // Left edge of the ball, double pixels
  squashPkg::courtY_t ballY;      // Top edge of the ball, double pixels
  logic ballDirX;  // High moves right
  logic ballDirY;  // High moves down
  logic hit;       // Ball touched the paddle since the paddle line last went by
  logic inBallX;   // Scan is inside the ball's columns
  logic inBallY;   // Scan is inside the ball's lines

  logic wallL, wallR, wallT, wallB;
  logic paddleHit;
  logic frameEnd;
  squashPkg::courtX_t ballXEnd;           // First column after the ball
  squashPkg::scanCoord_t ballYEnd;        // First double line after the ball, 9 bits used
  squashPkg::scanCoord_t paddleEnd;       // First line after the paddle

  // Wall regions of the court; the left one is just the paddle strip
  assign wallL = scan.h < `WALL_WIDTH;
  assign wallR = scan.h >= wallRLimit;
  assign wallT = scan.v < `WALL_WIDTH;
  assign wallB = scan.v >= wallBLimit;

  assign ballXEnd  = ballX + squashPkg::courtX_t'(`BALL_SIZE);
  assign ballYEnd  = {2'b00, ballY} + squashPkg::scanCoord_t'(`BALL_SIZE);
  assign paddleEnd = {1'b0, paddle} + squashPkg::scanCoord_t'(`PADDLE_SIZE);

  // Ball, paddle and the left strip all overlap on this pixel
  assign paddleHit = inBallX && inBallY && inPaddle && wallL;

  // Play only advances on the very last clock of an unpaused frame
  assign frameEnd = scan.hMax && scan.vMax && !ctrl.paused;

  always_ff @(posedge clk) begin
    if (reset) begin
      paddle   <= squashPkg::paddlePos_t'(`PADDLE_RESET);
      ballX    <= squashPkg::courtX_t'(`BALL_RESET);
      ballY    <= squashPkg::courtY_t'(`BALL_RESET);
      ballDirX <= 1'b1;
      ballDirY <= 1'b1;
      hit      <= 1'b0;
      inBallX  <= 1'b0;
      inBallY  <= 1'b0;
      inPaddle <= 1'b0;
    end else begin
      // Open the column span on the ball's left edge and close it one ball width later
      if (inBallX) begin
        inBallX <= (scan.h[9:1] != ballXEnd) && (ballX < ballXLimit);
      end else begin
        inBallX <= (scan.h[9:1] == ballX) && (ballX < ballXLimit);
      end

      // Horizontal bounces: the paddle sends the ball right, the right wall sends it back
      if (paddleHit) begin
        ballDirX <= 1'b1;
      end else if (inBallX && wallR) begin
        ballDirX <= 1'b0;
      end

      if (inBallY && wallB) begin
        ballDirY <= 1'b0;  // Going up again
      end else if (inBallY && wallT) begin
        ballDirY <= 1'b1;
      end

      // The tone stops once the scan passes the paddle line, so it lasts about a frame
      if (ctrl.newGame) begin
        hit <= 1'b0;
      end else if (scan.hMax && (scan.v[8:0] == paddle)) begin
        hit <= 1'b0;
      end else if (paddleHit) begin
        hit <= 1'b1;
      end

      // Line spans are decided at the end of each line for the next one
      if (scan.hMax) begin
        if (scan.v[8:0] == paddle) begin
          inPaddle <= 1'b1;
        end else if (scan.v == paddleEnd) begin
          inPaddle <= 1'b0;
        end
        // Ball rows are double lines, so only v[9:1] is compared
        if (inBallY) begin
          inBallY <= {1'b0, scan.v[9:1]} != ballYEnd;
        end else begin
          inBallY <= scan.v[9:1] == {1'b0, ballY};
        end
      end

      if (ctrl.newGame) begin
        paddle <= squashPkg::paddlePos_t'(`PADDLE_RESET);  // Directions are left as they are
        ballX  <= squashPkg::courtX_t'(`BALL_RESET);
        ballY  <= squashPkg::courtY_t'(`BALL_RESET);
      end else if (frameEnd) begin
        if (ctrl.down && (paddle < `PADDLE_MAX)) begin
          paddle <= paddle + 9'd2;
        end else if (ctrl.up && (paddle > `PADDLE_MIN)) begin
          paddle <= paddle - 9'd2;
        end
        // Three double pixels per frame is six on screen
        ballX <= ballDirX ? ballX + 9'd3 : ballX - 9'd3;
        ballY <= ballDirY ? ballY + 8'd3 : ballY - 8'd3;
      end
    end
  end

  assign inBall = inBallX && inBallY;

  // Short beep after a paddle hit, lower buzz while the ball is at or past a wall
  assign speaker = (scan.v[5] && hit) ||
                   (scan.v[6] && ((ballX >= wallRLimit / 2 - `BALL_SIZE) ||
                                  (ballY < `WALL_WIDTH / 2) ||
                                  (ballY >= wallBLimit / 2 - `BALL_SIZE)));

endmodule

`default_nettype wire

// File: design/pixelPainter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel colors for the squash court
// Green walls with red mortar, green ball, red paddle
// Animated blue background pattern
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "squash_config.svh"

module pixelPainter (
  input wire  clk,
  input wire  reset,
  scanIf.viewer scan,
  input wire  inBall,
  input wire  inPaddle,
  input wire  paused,
  output logic red,
  output logic green,
  output logic blue
);

  localparam int wallRLimit = `H_RES - `WALL_WIDTH;
  localparam int wallBLimit = `V_RES - `WALL_WIDTH;

  squashPkg::frameOffset_t offset;  // Steps once per unpaused frame
  logic wallL, wallR, wallT, wallB;
  logic anyWall;
  logic [4:0] hMortar, vMortar;      // Position shifted by 2 so mortar sits inside the brick
  squashPkg::scanCoord_t offH, offV;  // Scan shifted by the animation offset

  always_ff @(posedge clk) begin
    if (reset) begin
      offset <= '0;
    end else if (scan.hMax && scan.vMax && !paused) begin
      offset <= offset + 5'd1;
    end
  end

  assign wallL   = scan.h < `WALL_WIDTH;  // Paddle strip, no wall is drawn there
  assign wallR   = scan.h >= wallRLimit;
  assign wallT   = scan.v < `WALL_WIDTH;
  assign wallB   = scan.v >= wallBLimit;
  assign anyWall = wallT || wallB || wallR;

  assign green = scan.visible && (anyWall || inBall);

  assign hMortar = scan.h[4:0] - 5'd2;
  assign vMortar = scan.v[4:0] - 5'd2;

  // Mortar over green comes out yellow
  assign red = scan.visible &&
               ((anyWall && (&vMortar[4:2] || &hMortar[4:2])) ||
                (wallL && inPaddle));

  // Only the upper four offset bits move the pattern, half a pixel per frame
  assign offH = scan.h - {6'b000000, offset[4:1]};
  assign offV = scan.v - {6'b000000, offset[4:1]};

  // Background fills whatever the court leaves dark
  assign blue = scan.visible && !green && !red &&
                (^(offH[4:2] ^ offV[4:2])) &&
                ((offH[4] ^ offV[4]) ? (offH[0] && offV[0]) : (offH[0] ^ offV[0]));

endmodule

`default_nettype wire

// File: design/soloSquash.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the one-player squash game
// Scan timer, button conditioning, court and painter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module soloSquash (
  input wire  clk,       // 25 MHz pixel clock
  input wire  reset,
  input wire  pauseN,
  input wire  newGameN,
  input wire  downKeyN,
  input wire  upKeyN,
  output logic hsync,
  output logic vsync,
  output logic speaker,
  output logic red,
  output logic green,
  output logic blue,
  output squashPkg::scanCoord_t hPos,  // Current scan pixel, for locating it in simulation
  output squashPkg::scanCoord_t vPos   // Current scan line
);

  scanIf scanBus ();
  controlIf ctrlBus ();

  logic inBall;
  logic inPaddle;

  scanTimer scanTimerInst (
    .clk   (clk),
    .reset (reset),
    .scan  (scanBus.timer),
    .hsync (hsync),
    .vsync (vsync)
  );

  playControls playControlsInst (
    .clk      (clk),
    .reset    (reset),
    .pauseN   (pauseN),
    .newGameN (newGameN),
    .downKeyN (downKeyN),
    .upKeyN   (upKeyN),
    .ctrl     (ctrlBus.source)
  );

  courtState courtStateInst (
    .clk      (clk),
    .reset    (reset),
    .scan     (scanBus.viewer),
    .ctrl     (ctrlBus.sink),
    .inBall   (inBall),
    .inPaddle (inPaddle),
    .speaker  (speaker)
  );

  // The painter animates on its own and needs the pause level too
  pixelPainter pixelPainterInst (
    .clk      (clk),
    .reset    (reset),
    .scan     (scanBus.viewer),
    .inBall   (inBall),
    .inPaddle (inPaddle),
    .paused   (ctrlBus.paused),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

  assign hPos = scanBus.h;
  assign vPos = scanBus.v;

endmodule

`default_nettype wire

// File: bench/soloSquashTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the squash game top level
// Scan, blanking, walls and speaker as concurrent assertions
// Paddle move, new game and pause checked on the left strip
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "squash_config.svh"

module soloSquashTb;

  localparam int frameLimit  = `H_FULL * `V_FULL + 1000;  // One frame plus a margin
  localparam int probeH      = `WALL_WIDTH / 2;           // Middle of the paddle strip
  localparam int bottomWall  = `V_RES - `WALL_WIDTH;
  localparam int hSyncFirst  = `H_RES + `H_FRONT;
  localparam int hSyncLast   = hSyncFirst + `H_SYNC - 1;
  localparam int vSyncFirst  = `V_RES + `V_FRONT;
  localparam int vSyncLast   = vSyncFirst + `V_SYNC - 1;
  localparam int movedFrames = 3;

  logic clk;
  logic reset;
  logic pauseN, newGameN, downKeyN, upKeyN;
  logic hsync, vsync, speaker;
  logic red, green, blue;
  squashPkg::scanCoord_t hPos;
  squashPkg::scanCoord_t vPos;

  logic armed;            // At least one clean clock since reset
  int prevH, prevV;       // Scan position seen at the previous edge
  int expH, expV;         // Where the scan should be now
  logic expHsync, expVsync;
  logic visiblePix;
  int topLine;
  int pausedFirst, pausedSecond;

  soloSquash soloSquash_inst (
    .clk      (clk),
    .reset    (reset),
    .pauseN   (pauseN),
    .newGameN (newGameN),
    .downKeyN (downKeyN),
    .upKeyN   (upKeyN),
    .hsync    (hsync),
    .vsync    (vsync),
    .speaker  (speaker),
    .red      (red),
    .green    (green),
    .blue     (blue),
    .hPos     (hPos),
    .vPos     (vPos)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    armed <= !reset;
    prevH <= hPos;
    prevV <= vPos;
  end

  // Expected scan from the VGA timing rules
  always_comb begin
    expH = (prevH == `H_FULL - 1) ? 0 : prevH + 1;
    if (prevH != `H_FULL - 1) begin
      expV = prevV;  // Line only steps with the wrap
    end else if (prevV == `V_FULL - 1) begin
      expV = 0;
    end else begin
      expV = prevV + 1;
    end
    expHsync   = !(hPos >= hSyncFirst && hPos <= hSyncLast);
    expVsync   = !(vPos >= vSyncFirst && vPos <= vSyncLast);
    visiblePix = (hPos < `H_RES) && (vPos < `V_RES);
  end

  task automatic failRun();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string testName, input int expected, input int actual);
    $display("error %s: expected %0d, actual %0d", testName, expected, actual);
    failRun();
  endtask

  task automatic reportFailure(input string what);
    $display("%s", what);
    failRun();
  endtask

  // Step on falling edges until the scan sits at the given pixel
  task automatic waitScan(input int h, input int v);
    int cycles;
    cycles = 0;
    while (!(hPos == h && vPos == v)) begin
      @(negedge clk);
      cycles++;
      if (cycles > frameLimit) begin
        reportFailure($sformatf("timed out waiting for scan position %0d,%0d", h, v));
      end
    end
  endtask

  // First line below the top wall where the left strip turns red
  task automatic findPaddleTop(output int line);
    int cycles;
    cycles = 0;
    line = -1;
    waitScan(probeH, `WALL_WIDTH);  // Skips the top wall mortar
    while (line < 0) begin
      if (hPos == probeH && red) begin
        line = vPos;
      end else begin
        if (vPos >= bottomWall) begin
          reportFailure("paddle never drawn in the left strip above the bottom wall");
        end
        @(negedge clk);
        cycles++;
        if (cycles > frameLimit) begin
          reportFailure("timed out looking for the paddle in the left strip");
        end
      end
    end
  endtask

  scanH: assert property (@(posedge clk) disable iff (reset) armed |-> hPos == expH)
    else reportMismatch("scan hPos", $sampled(expH), $sampled(hPos));
  scanV: assert property (@(posedge clk) disable iff (reset) armed |-> vPos == expV)
    else reportMismatch("scan vPos", $sampled(expV), $sampled(vPos));
  hsyncPulse: assert property (@(posedge clk) disable iff (reset) hsync == expHsync)
    else reportMismatch("hsync", $sampled(expHsync), $sampled(hsync));
  vsyncPulse: assert property (@(posedge clk) disable iff (reset) vsync == expVsync)
    else reportMismatch("vsync", $sampled(expVsync), $sampled(vsync));

  // Colors packed as red, green, blue
  blanking: assert property (@(posedge clk) disable iff (reset)
      !visiblePix |-> {red, green, blue} == 3'b000)
    else reportMismatch("blanking", 0, $sampled({red, green, blue}));

  // Green on and blue off, packed as green, blue
  walls: assert property (@(posedge clk) disable iff (reset)
      (visiblePix && (vPos < `WALL_WIDTH || hPos >= `H_RES - `WALL_WIDTH)) |-> green && !blue)
    else reportMismatch("walls", 2, $sampled({green, blue}));

  // The ball starts clear of the walls and moves right, so neither a hit nor a wall buzz sounds
  quietSpeaker: assert property (@(posedge clk) disable iff (reset) !speaker)
    else reportMismatch("speaker", 0, $sampled(speaker));

  initial begin
    reset    = 1'b1;
    pauseN   = 1'b1;  // Buttons idle released
    newGameN = 1'b1;
    downKeyN = 1'b1;
    upKeyN   = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // Down held over three frame ends, two pixels each
    waitScan(0, 0);
    downKeyN = 1'b0;
    repeat (movedFrames) begin
      waitScan(`H_FULL - 1, `V_FULL - 1);
      @(negedge clk);
    end
    downKeyN = 1'b1;  // Gone long before the next frame end
    findPaddleTop(topLine);
    paddleMoved: assert (topLine == `PADDLE_RESET + 2 * movedFrames + 1)
      else reportMismatch("paddle move", `PADDLE_RESET + 2 * movedFrames + 1, topLine);

    newGameN = 1'b0;
    repeat (4) @(negedge clk);
    newGameN = 1'b1;
    findPaddleTop(topLine);  // Next frame, paddle back at its start
    paddleRestored: assert (topLine == `PADDLE_RESET + 1)
      else reportMismatch("new game", `PADDLE_RESET + 1, topLine);

    // Down stays pressed, so any frame that slips through would move the paddle
    pauseN   = 1'b0;
    downKeyN = 1'b0;
    findPaddleTop(pausedFirst);
    findPaddleTop(pausedSecond);
    pauseHolds: assert (pausedSecond == pausedFirst)
      else reportMismatch("pause", pausedFirst, pausedSecond);
    pauseN   = 1'b1;
    downKeyN = 1'b1;

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/squashPkg.sv
design/scanIf.sv
design/controlIf.sv
design/scanTimer.sv
design/playControls.sv
design/courtState.sv
design/pixelPainter.sv
design/soloSquash.sv
bench/soloSquashTb.sv
